// File: verilog/rv32_pkg.sv
package rv32_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Debug pattern for the PC fields of a flushed entry
    localparam logic [XLEN-1:0] FLUSH_PC = 32'h2A2A_2A2A;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // Supported major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // Operand B straight through, for LUI
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Same values as funct3 of the branch instructions
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

    // Writeback source
    typedef enum logic {
        RES_ALU = 1'b0,
        RES_PC4 = 1'b1
    } result_src_e;

endpackage

// File: verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [rv32_pkg::XLEN-1:0]       instr,
    output logic                            dec_valid_op,
    output logic                            reg_w_en,
    output logic                            jump_en,
    output logic                            branch_en,
    output logic                            alu_src_a_pc,
    output logic                            alu_src_b_imm,
    output rv32_pkg::alu_op_e               alu_op,
    output rv32_pkg::branch_cond_e          branch_cond,
    output rv32_pkg::result_src_e           result_src,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv32_pkg::XLEN-1:0]       imm_ext
);

    import rv32_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // Register fields sit in fixed positions
    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        // Bubble unless an opcode below matches
        dec_valid_op  = 1'b0;
        reg_w_en      = 1'b0;
        jump_en       = 1'b0;
        branch_en     = 1'b0;
        alu_src_a_pc  = 1'b0;
        alu_src_b_imm = 1'b0;
        alu_op        = ALU_ADD;
        branch_cond   = BR_EQ;
        result_src    = RES_ALU;
        // I-type immediate
        imm_ext       = {{20{instr[31]}}, instr[31:20]};

        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                dec_valid_op  = 1'b1;
                reg_w_en      = 1'b1;
                alu_src_b_imm = (opcode == OPC_OP_IMM);
                case (funct3)
                    // SUB only for the register form, ADDI ignores bit 30
                    3'b000:  alu_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                dec_valid_op  = 1'b1;
                reg_w_en      = 1'b1;
                alu_src_b_imm = 1'b1;
                alu_src_a_pc  = (opcode == OPC_AUIPC);
                alu_op        = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                // U-type
                imm_ext       = {instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                dec_valid_op = 1'b1;
                reg_w_en     = 1'b1;
                jump_en      = 1'b1;
                alu_src_a_pc = 1'b1;
                result_src   = RES_PC4;
                // J-type
                imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                // Target is rs1 + imm from the ALU
                dec_valid_op  = 1'b1;
                reg_w_en      = 1'b1;
                jump_en       = 1'b1;
                alu_src_b_imm = 1'b1;
                result_src    = RES_PC4;
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) begin
                    dec_valid_op = 1'b1;
                    branch_en    = 1'b1;
                    branch_cond  = branch_cond_e'(funct3);
                end
                // B-type
                imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            default: ;
        endcase

        // x0 is never written
        if (rd == '0) begin
            reg_w_en = 1'b0;
        end
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rv32_pkg::XLEN-1:0]       rs1_data,
    output logic [rv32_pkg::XLEN-1:0]       rs2_data,
    input  logic                            wb_en,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [rv32_pkg::XLEN-1:0]       wb_data
);

    import rv32_pkg::*;

    // x1..x31, no storage for x0
    logic [XLEN-1:0] regs [1:31];

    // Read port 1 with x0 tie-off and same-cycle write bypass
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wb_en && wb_rd == rs1_addr) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    // Read port 2, same rules
    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wb_en && wb_rd == rs2_addr) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// File: verilog/idex_register.sv
`timescale 1ns/1ps

module idex_register (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            flush,

    // Decode side
    input  logic                            d_valid,
    input  logic                            d_reg_w_en,
    input  logic                            d_jump_en,
    input  logic                            d_branch_en,
    input  logic                            d_alu_src_a_pc,
    input  logic                            d_alu_src_b_imm,
    input  logic                            d_predict_taken,
    input  rv32_pkg::alu_op_e               d_alu_op,
    input  rv32_pkg::branch_cond_e          d_branch_cond,
    input  rv32_pkg::result_src_e           d_result_src,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] d_rd,
    input  logic [rv32_pkg::XLEN-1:0]       d_rs1_data,
    input  logic [rv32_pkg::XLEN-1:0]       d_rs2_data,
    input  logic [rv32_pkg::XLEN-1:0]       d_imm_ext,
    input  logic [rv32_pkg::XLEN-1:0]       d_pc,
    input  logic [rv32_pkg::XLEN-1:0]       d_pc_plus_4,

    // Execute side
    output logic                            e_valid,
    output logic                            e_reg_w_en,
    output logic                            e_jump_en,
    output logic                            e_branch_en,
    output logic                            e_alu_src_a_pc,
    output logic                            e_alu_src_b_imm,
    output logic                            e_predict_taken,
    output rv32_pkg::alu_op_e               e_alu_op,
    output rv32_pkg::branch_cond_e          e_branch_cond,
    output rv32_pkg::result_src_e           e_result_src,
    output logic [rv32_pkg::REG_ADDR_W-1:0] e_rd,
    output logic [rv32_pkg::XLEN-1:0]       e_rs1_data,
    output logic [rv32_pkg::XLEN-1:0]       e_rs2_data,
    output logic [rv32_pkg::XLEN-1:0]       e_imm_ext,
    output logic [rv32_pkg::XLEN-1:0]       e_pc,
    output logic [rv32_pkg::XLEN-1:0]       e_pc_plus_4
);

    import rv32_pkg::*;

    always_ff @(posedge CLK) begin
        if (RST) begin
            // Only fields that can change state
            e_valid         <= 1'b0;
            e_reg_w_en      <= 1'b0;
            e_jump_en       <= 1'b0;
            e_branch_en     <= 1'b0;
            e_predict_taken <= 1'b0;
        end else if (flush) begin
            // Bubble in place of the wrong-path instruction
            e_valid         <= 1'b0;
            e_reg_w_en      <= 1'b0;
            e_jump_en       <= 1'b0;
            e_branch_en     <= 1'b0;
            e_predict_taken <= 1'b0;
            // Marks the squashed slot in waveforms
            e_pc            <= FLUSH_PC;
            e_pc_plus_4     <= FLUSH_PC;
        end else begin
            e_valid         <= d_valid;
            e_reg_w_en      <= d_reg_w_en;
            e_jump_en       <= d_jump_en;
            e_branch_en     <= d_branch_en;
            e_alu_src_a_pc  <= d_alu_src_a_pc;
            e_alu_src_b_imm <= d_alu_src_b_imm;
            e_predict_taken <= d_predict_taken;
            e_alu_op        <= d_alu_op;
            e_branch_cond   <= d_branch_cond;
            e_result_src    <= d_result_src;
            e_rd            <= d_rd;
            e_rs1_data      <= d_rs1_data;
            e_rs2_data      <= d_rs2_data;
            e_imm_ext       <= d_imm_ext;
            e_pc            <= d_pc;
            e_pc_plus_4     <= d_pc_plus_4;
        end
    end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                            e_valid,
    input  logic                            e_reg_w_en,
    input  logic                            e_jump_en,
    input  logic                            e_branch_en,
    input  logic                            e_alu_src_a_pc,
    input  logic                            e_alu_src_b_imm,
    input  logic                            e_predict_taken,
    input  rv32_pkg::alu_op_e               e_alu_op,
    input  rv32_pkg::branch_cond_e          e_branch_cond,
    input  rv32_pkg::result_src_e           e_result_src,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] e_rd,
    input  logic [rv32_pkg::XLEN-1:0]       e_rs1_data,
    input  logic [rv32_pkg::XLEN-1:0]       e_rs2_data,
    input  logic [rv32_pkg::XLEN-1:0]       e_imm_ext,
    input  logic [rv32_pkg::XLEN-1:0]       e_pc,
    input  logic [rv32_pkg::XLEN-1:0]       e_pc_plus_4,
    output logic                            wb_en,
    output logic [rv32_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv32_pkg::XLEN-1:0]       wb_data,
    output logic                            redirect,
    output logic [rv32_pkg::XLEN-1:0]       redirect_pc
);

    import rv32_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] target;
    logic            cond_true;
    logic            taken;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    assign op_a = e_alu_src_a_pc  ? e_pc      : e_rs1_data;
    assign op_b = e_alu_src_b_imm ? e_imm_ext : e_rs2_data;

    always_comb begin
        case (e_alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (e_branch_cond)
            BR_NE:   cond_true = e_rs1_data != e_rs2_data;
            BR_LT:   cond_true = $signed(e_rs1_data) < $signed(e_rs2_data);
            BR_GE:   cond_true = $signed(e_rs1_data) >= $signed(e_rs2_data);
            BR_LTU:  cond_true = e_rs1_data < e_rs2_data;
            BR_GEU:  cond_true = e_rs1_data >= e_rs2_data;
            default: cond_true = e_rs1_data == e_rs2_data;
        endcase
    end

    // Jumps always taken
    assign taken = e_jump_en | (e_branch_en & cond_true);

    // JALR gets rs1 + imm from the ALU, bit 0 cleared
    assign target = (e_jump_en && !e_alu_src_a_pc && e_alu_src_b_imm)
                  ? {alu_result[XLEN-1:1], 1'b0}
                  : e_pc + e_imm_ext;

    // Mispredict in either direction
    assign redirect    = e_valid & (taken != e_predict_taken);
    assign redirect_pc = taken ? target : e_pc_plus_4;

    // Writeback, rd zero already masked in decode
    assign wb_en   = e_valid & e_reg_w_en;
    assign wb_rd   = e_rd;
    assign wb_data = (e_result_src == RES_PC4) ? e_pc_plus_4 : alu_result;

endmodule

// File: verilog/decode_execute.sv
`timescale 1ns/1ps

module decode_execute (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            instr_valid,
    input  logic                            predict_taken,
    input  logic [rv32_pkg::XLEN-1:0]       instr,
    input  logic [rv32_pkg::XLEN-1:0]       pc,
    output logic                            wb_en,
    output logic                            redirect,
    output logic [rv32_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv32_pkg::XLEN-1:0]       wb_data,
    output logic [rv32_pkg::XLEN-1:0]       redirect_pc
);

    import rv32_pkg::*;

    // Decode stage
    logic                  dec_valid_op, reg_w_en, jump_en, branch_en;
    logic                  alu_src_a_pc, alu_src_b_imm;
    alu_op_e               alu_op;
    branch_cond_e          branch_cond;
    result_src_e           result_src;
    logic [REG_ADDR_W-1:0] rd, rs1, rs2;
    logic [XLEN-1:0]       imm_ext, rs1_data, rs2_data, pc_plus_4;

    // Execute stage
    logic                  e_valid, e_reg_w_en, e_jump_en, e_branch_en;
    logic                  e_alu_src_a_pc, e_alu_src_b_imm, e_predict_taken;
    alu_op_e               e_alu_op;
    branch_cond_e          e_branch_cond;
    result_src_e           e_result_src;
    logic [REG_ADDR_W-1:0] e_rd;
    logic [XLEN-1:0]       e_rs1_data, e_rs2_data, e_imm_ext, e_pc, e_pc_plus_4;

    // Link address
    assign pc_plus_4 = pc + 32'd4;

    decoder i_decoder (
        .instr, .dec_valid_op, .reg_w_en, .jump_en, .branch_en, .alu_src_a_pc,
        .alu_src_b_imm, .alu_op, .branch_cond, .result_src, .rd, .rs1, .rs2, .imm_ext
    );

    // Written by execute, read by decode in the same cycle
    register_file i_register_file (
        .CLK, .RST, .rs1_addr(rs1), .rs2_addr(rs2), .rs1_data, .rs2_data,
        .wb_en, .wb_rd, .wb_data
    );

    // A redirect squashes the instruction now in decode
    idex_register i_idex_register (
        .CLK, .RST, .flush(redirect),
        .d_valid(instr_valid & dec_valid_op), .d_reg_w_en(reg_w_en),
        .d_jump_en(jump_en), .d_branch_en(branch_en), .d_alu_src_a_pc(alu_src_a_pc),
        .d_alu_src_b_imm(alu_src_b_imm), .d_predict_taken(predict_taken),
        .d_alu_op(alu_op), .d_branch_cond(branch_cond), .d_result_src(result_src),
        .d_rd(rd), .d_rs1_data(rs1_data), .d_rs2_data(rs2_data), .d_imm_ext(imm_ext),
        .d_pc(pc), .d_pc_plus_4(pc_plus_4),
        .e_valid, .e_reg_w_en, .e_jump_en, .e_branch_en, .e_alu_src_a_pc,
        .e_alu_src_b_imm, .e_predict_taken, .e_alu_op, .e_branch_cond, .e_result_src,
        .e_rd, .e_rs1_data, .e_rs2_data, .e_imm_ext, .e_pc, .e_pc_plus_4
    );

    execute_unit i_execute_unit (
        .e_valid, .e_reg_w_en, .e_jump_en, .e_branch_en, .e_alu_src_a_pc,
        .e_alu_src_b_imm, .e_predict_taken, .e_alu_op, .e_branch_cond, .e_result_src,
        .e_rd, .e_rs1_data, .e_rs2_data, .e_imm_ext, .e_pc, .e_pc_plus_4,
        .wb_en, .wb_rd, .wb_data, .redirect, .redirect_pc
    );

endmodule

// File: testbench/de_checker.sv
`timescale 1ns/1ps

module de_checker (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            instr_valid,
    input  logic                            predict_taken,
    input  logic [rv32_pkg::XLEN-1:0]       instr,
    input  logic [rv32_pkg::XLEN-1:0]       pc,
    input  logic                            wb_en,
    input  logic                            redirect,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [rv32_pkg::XLEN-1:0]       wb_data,
    input  logic [rv32_pkg::XLEN-1:0]       redirect_pc,
    output int                              error_count,
    output int                              check_count
);

    import rv32_pkg::*;

    // Architectural view of x0..x31
    logic [XLEN-1:0]       mirror [0:31];

    // Expected outputs of the instruction now in execute
    logic                  exp_valid;
    logic                  exp_wb_en;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]       exp_data;
    logic                  exp_redirect;
    logic [XLEN-1:0]       exp_redirect_pc;

    initial begin
        error_count  = 0;
        check_count  = 0;
        exp_valid    = 1'b0;
        exp_wb_en    = 1'b0;
        exp_redirect = 1'b0;
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t ns",
                     name, actual, expected, $time);
        end
    endtask

    function automatic logic [XLEN-1:0] reg_value(input logic [4:0] addr);
        return (addr == 5'd0) ? '0 : mirror[addr];
    endfunction

    // RV32I integer ops by funct3, alt is funct7 bit 5 where it matters
    function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] x,
                                                  input logic [XLEN-1:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101: begin
                if (alt) begin
                    return $signed(x) >>> y[4:0];
                end
                return x >> y[4:0];
            end
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_holds(input logic [2:0] f3, input logic [XLEN-1:0] x,
                                          input logic [XLEN-1:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    // Expected execute-stage outputs of an accepted instruction
    task automatic model_instr(input logic [XLEN-1:0] ins, input logic [XLEN-1:0] ipc,
                               input logic pred);
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_u;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] tgt;
        logic            ok;
        logic            writes;
        logic            taken;
        f3    = ins[14:12];
        // Mirror already holds this cycle's writeback, as the bypass does
        a     = reg_value(ins[19:15]);
        b     = reg_value(ins[24:20]);
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        ok     = 1'b1;
        writes = 1'b0;
        taken  = 1'b0;
        res    = '0;
        tgt    = '0;
        case (ins[6:0])
            7'b0110011: begin
                writes = 1'b1;
                res    = alu_model(f3, ins[30], a, b);
            end
            7'b0010011: begin
                // ADDI has no subtract form
                writes = 1'b1;
                res    = alu_model(f3, ins[30] && f3 == 3'b101, a, imm_i);
            end
            7'b0110111: begin
                writes = 1'b1;
                res    = imm_u;
            end
            7'b0010111: begin
                writes = 1'b1;
                res    = ipc + imm_u;
            end
            7'b1101111: begin
                writes = 1'b1;
                taken  = 1'b1;
                res    = ipc + 32'd4;
                tgt    = ipc + imm_j;
            end
            7'b1100111: begin
                writes = 1'b1;
                taken  = 1'b1;
                res    = ipc + 32'd4;
                tgt    = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    ok = 1'b0;
                end else begin
                    taken = branch_holds(f3, a, b);
                    tgt   = ipc + imm_b;
                end
            end
            default: ok = 1'b0;
        endcase
        exp_valid       = ok;
        exp_wb_en       = ok && writes && ins[11:7] != 5'd0;
        exp_rd          = ins[11:7];
        exp_data        = res;
        exp_redirect    = ok && (taken != pred);
        exp_redirect_pc = taken ? tgt : ipc + 32'd4;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare at the falling edge, mid-cycle where all outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (RST !== 1'b0) begin
            // Start from an empty pipe, first cycle after reset expects a bubble
            for (int i = 0; i < 32; i++) begin
                mirror[i] = '0;
            end
            exp_valid    = 1'b0;
            exp_wb_en    = 1'b0;
            exp_redirect = 1'b0;
        end else begin
            if (exp_valid) begin
                check_value("wb_en", wb_en, exp_wb_en);
                if (exp_wb_en) begin
                    check_value("wb_rd", wb_rd, exp_rd);
                    check_value("wb_data", wb_data, exp_data);
                end
                check_value("redirect", redirect, exp_redirect);
                check_value("redirect_pc", redirect_pc, exp_redirect_pc);
            end else begin
                // Bubble
                check_value("wb_en", wb_en, 1'b0);
                check_value("redirect", redirect, 1'b0);
            end
            if (exp_valid && exp_wb_en) begin
                mirror[exp_rd] = exp_data;
            end
            // Next edge takes the presented instruction unless it is flushed
            if (instr_valid && !exp_redirect) begin
                model_instr(instr, pc, predict_taken);
            end else begin
                exp_valid    = 1'b0;
                exp_wb_en    = 1'b0;
                exp_redirect = 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_decode_execute.sv
`timescale 1ns/1ps

module tb_decode_execute;

    import rv32_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int NUM_INSTR     = 2000;
    // Reset, drain and slack
    localparam int MARGIN_CYCLES = 50;

    logic                  CLK;
    logic                  RST;
    logic                  instr_valid;
    logic                  predict_taken;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc;
    logic                  wb_en;
    logic                  redirect;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic [XLEN-1:0]       redirect_pc;
    int                    error_count;
    int                    check_count;
    logic [31:0]           rng_state;

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    decode_execute i_dut (
        .CLK, .RST, .instr_valid, .predict_taken, .instr, .pc,
        .wb_en, .redirect, .wb_rd, .wb_data, .redirect_pc
    );

    de_checker i_checker (
        .CLK, .RST, .instr_valid, .predict_taken, .instr, .pc,
        .wb_en, .redirect, .wb_rd, .wb_data, .redirect_pc,
        .error_count, .check_count
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random instruction source
    ////////////////////////////////////////////////////////////////////////////

    // LCG, upper half only since the low bits repeat quickly
    function automatic logic [15:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    function automatic logic [31:0] build_instr();
        logic [15:0] sel;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        sel = lcg_next();
        r   = rand_word();
        // x0..x7 only, so results feed the next few instructions
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = r[11:9];
        case (sel[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                // SUB and SRA carry funct7 bit 5
                f7 = (r[12] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            4'd4, 4'd5, 4'd6, 4'd7: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    // Shift by immediate, shamt in bits 24:20
                    f7 = (r[12] && f3 == 3'b101) ? 7'b0100000 : 7'b0000000;
                    return {f7, r[17:13], rs1, f3, rd, 7'b0010011};
                end
                return {r[31:20], rs1, f3, rd, 7'b0010011};
            end
            4'd8:  return {r[31:12], rd, 7'b0110111};
            4'd9:  return {r[31:12], rd, 7'b0010111};
            4'd10: return {r[31:12], rd, 7'b1101111};
            4'd11: return {r[31:20], rs1, 3'b000, rd, 7'b1100111};
            4'd12, 4'd13, 4'd14: begin
                // Fold funct3 010/011 onto real branches
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                return {r[31:25], rs2, rs1, f3, r[16:12], 7'b1100011};
            end
            default: begin
                // Outside the supported set, must act as a bubble
                case (r[13:12])
                    2'd0:    return {r[31:20], rs1, f3, rd, 7'b0000011};
                    2'd1:    return {r[31:25], rs2, rs1, f3, r[16:12], 7'b0100011};
                    2'd2:    return {r[31:20], rs1, f3, rd, 7'b1110011};
                    default: return {r[31:25], rs2, rs1, 2'b01, r[14], r[19:15], 7'b1100011};
                endcase
            end
        endcase
    endfunction

    task automatic drive_random();
        logic [15:0] ctl;
        logic [31:0] pc_word;
        ctl           = lcg_next();
        pc_word       = rand_word();
        instr         = build_instr();
        pc            = {pc_word[31:2], 2'b00};
        // Valid about seven cycles in eight
        instr_valid   = (ctl[2:0] != 3'd0);
        predict_taken = ctl[3];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rng_state     = 32'hc171;
        RST           = 1'b1;
        instr_valid   = 1'b0;
        predict_taken = 1'b0;
        instr         = '0;
        pc            = '0;
        repeat (2) @(posedge CLK);
        #DRIVE_DELAY;
        RST = 1'b0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            drive_random();
            @(posedge CLK);
            #DRIVE_DELAY;
        end
        instr_valid = 1'b0;
        // Last instruction still in execute, counts settle at the falling edge
        repeat (3) @(posedge CLK);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_INSTR + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the instruction stream finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: rv32_slice.f
verilog/rv32_pkg.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/idex_register.sv
verilog/execute_unit.sv
verilog/decode_execute.sv
testbench/de_checker.sv
testbench/tb_decode_execute.sv

// File: Bender.yml
package:
  name: rv32_slice

sources:
  # Package first, then leaf modules, then the top level
  - verilog/rv32_pkg.sv
  - verilog/decoder.sv
  - verilog/register_file.sv
  - verilog/idex_register.sv
  - verilog/execute_unit.sv
  - verilog/decode_execute.sv

  - target: test
    files:
      - testbench/de_checker.sv
      - testbench/tb_decode_execute.sv
